// File: design/vid_pattern_gen.sv
`timescale 1ns/1ps

module vid_pattern_gen #(
	parameter int bar_shift   = 1,
	parameter int check_shift = 2
) (
	input  logic                  vid_clk_in,
	input  logic                  reset_logic_n,
	input  vid_pkg::vid_sync_t    timing_in,
	input  vid_pkg::vid_pattern_e pattern_sel,
	input  vid_pkg::vid_rgb_t     solid_rgb,
	output vid_pkg::vid_sync_t    timing_out,
	output vid_pkg::vid_rgb_t     pixel
);
	import vid_pkg::*;

	// pattern in use for the current frame
	vid_pattern_e         pat_q;
	// previous vs for edge detect
	logic                 vs_q;
	// zero-based active position
	logic [vid_cnt_w-1:0] h_zero;
	logic [vid_cnt_w-1:0] v_zero;
	// pixel position scaled to bar width
	logic [vid_cnt_w-1:0] bar_pos;
	logic [2:0]           bar_idx;
	logic                 check_on;
	vid_rgb_t             pix_next;

	// ----------------------------------------------------------------------
	// frame aligned pattern select
	// ----------------------------------------------------------------------

	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
		begin
			vs_q  <= 1'b0;
			pat_q <= pat_bars;
		end
		else
		begin
			vs_q <= timing_in.vs;
			// take the new select at frame start only
			if (timing_in.vs && !vs_q)
				pat_q <= pattern_sel;
		end
	end

	// ----------------------------------------------------------------------
	// pixel formation
	// ----------------------------------------------------------------------

	assign h_zero   = timing_in.h_cnt - vid_cnt_w'(1);
	assign v_zero   = timing_in.v_cnt - vid_cnt_w'(1);
	assign bar_pos  = h_zero >> bar_shift;
	// eight bars repeat across the line
	assign bar_idx  = bar_pos[2:0];
	assign check_on = h_zero[check_shift] ^ v_zero[check_shift];

	always_comb
	begin
		case (pat_q)
			pat_bars:
			begin
				// r g b taken from index bits 2 1 0
				pix_next.r = {8{bar_idx[2]}};
				pix_next.g = {8{bar_idx[1]}};
				pix_next.b = {8{bar_idx[0]}};
			end
			pat_ramp:
			begin
				// gray level follows the pixel position
				pix_next.r = h_zero[7:0];
				pix_next.g = h_zero[7:0];
				pix_next.b = h_zero[7:0];
			end
			pat_check:
				pix_next = check_on ? '1 : '0;
			default:
				pix_next = solid_rgb;
		endcase
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------

	// sync bundle delayed by one to stay with its pixel
	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
		begin
			timing_out <= '0;
			pixel      <= '0;
		end
		else
		begin
			timing_out <= timing_in;
			// black outside the active window
			pixel      <= timing_in.de ? pix_next : '0;
		end
	end

endmodule

// File: design/vid_pkg.sv
package vid_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------

	// width of every pixel and line counter and of each geometry word
	parameter int vid_cnt_w = 16;

	// ----------------------------------------------------------------------
	// geometry as given at the top level
	// ----------------------------------------------------------------------

	// horizontal fields in pixel clocks, vertical fields in lines
	typedef struct packed {
		logic [vid_cnt_w-1:0] hpixel;
		logic [vid_cnt_w-1:0] hfporch;
		logic [vid_cnt_w-1:0] hbporch;
		logic [vid_cnt_w-1:0] hpwidth;
		logic [vid_cnt_w-1:0] vpixel;
		logic [vid_cnt_w-1:0] vfporch;
		logic [vid_cnt_w-1:0] vbporch;
		logic [vid_cnt_w-1:0] vpwidth;
	} vid_geom_t;

	// ----------------------------------------------------------------------
	// derived compare values
	// ----------------------------------------------------------------------

	// all values are 1-based counter positions
	typedef struct packed {
		logic [vid_cnt_w-1:0] h_total;
		logic [vid_cnt_w-1:0] v_total;
		// first and last pixel of the active window
		logic [vid_cnt_w-1:0] h_de_first;
		logic [vid_cnt_w-1:0] h_de_last;
		// first and last active line
		logic [vid_cnt_w-1:0] v_de_first;
		logic [vid_cnt_w-1:0] v_de_last;
		// last counter value with sync high
		logic [vid_cnt_w-1:0] h_sync_end;
		logic [vid_cnt_w-1:0] v_sync_end;
	} vid_limits_t;

	// ----------------------------------------------------------------------
	// video stream
	// ----------------------------------------------------------------------

	// sync bundle with active pixel and line numbers
	typedef struct packed {
		logic                 hs;
		logic                 vs;
		logic                 de;
		logic [vid_cnt_w-1:0] h_cnt;
		logic [vid_cnt_w-1:0] v_cnt;
	} vid_sync_t;

	// 24-bit rgb pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vid_rgb_t;

	// test pattern select
	typedef enum logic [1:0] {
		pat_bars  = 2'd0,
		pat_ramp  = 2'd1,
		pat_check = 2'd2,
		pat_solid = 2'd3
	} vid_pattern_e;

endpackage

// File: design/vid_timing_cfg.sv
`timescale 1ns/1ps

module vid_timing_cfg (
	input  logic                 vid_clk_in,
	input  logic                 reset_logic_n,
	input  vid_pkg::vid_geom_t   geom,
	output vid_pkg::vid_limits_t limits,
	output logic                 cfg_ok
);
	import vid_pkg::*;

	// ----------------------------------------------------------------------
	// first adder level
	// ----------------------------------------------------------------------

	// registered copy of the geometry
	vid_geom_t            geom_q;
	// sync plus back porch
	logic [vid_cnt_w-1:0] h_lead_sum;
	logic [vid_cnt_w-1:0] v_lead_sum;
	// active plus front porch
	logic [vid_cnt_w-1:0] h_tail_sum;
	logic [vid_cnt_w-1:0] v_tail_sum;
	// set when any field is zero
	logic                 geom_zero;

	always_ff @(posedge vid_clk_in)
	begin
		geom_q     <= geom;
		h_lead_sum <= geom.hpwidth + geom.hbporch;
		v_lead_sum <= geom.vpwidth + geom.vbporch;
		h_tail_sum <= geom.hpixel + geom.hfporch;
		v_tail_sum <= geom.vpixel + geom.vfporch;
	end

	// zero field check
	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
			geom_zero <= 1'b1;
		else
			geom_zero <= (geom.hpixel == '0) || (geom.hfporch == '0) ||
				(geom.hbporch == '0) || (geom.hpwidth == '0) ||
				(geom.vpixel == '0) || (geom.vfporch == '0) ||
				(geom.vbporch == '0) || (geom.vpwidth == '0);
	end

	// ----------------------------------------------------------------------
	// second adder level
	// ----------------------------------------------------------------------

	always_ff @(posedge vid_clk_in)
	begin
		// full line and full frame
		limits.h_total    <= h_lead_sum + h_tail_sum;
		limits.v_total    <= v_lead_sum + v_tail_sum;
		// active window starts right after the back porch
		limits.h_de_first <= h_lead_sum + vid_cnt_w'(1);
		limits.h_de_last  <= h_lead_sum + geom_q.hpixel;
		limits.v_de_first <= v_lead_sum + vid_cnt_w'(1);
		limits.v_de_last  <= v_lead_sum + geom_q.vpixel;
		// sync starts at count 1
		limits.h_sync_end <= geom_q.hpwidth;
		limits.v_sync_end <= geom_q.vpwidth;
	end

	// valid flag lines up with the limits
	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
			cfg_ok <= 1'b0;
		else
			cfg_ok <= !geom_zero;
	end

endmodule

// File: design/vid_timing_gen.sv
`timescale 1ns/1ps

module vid_timing_gen (
	input  logic                 vid_clk_in,
	input  logic                 reset_logic_n,
	input  vid_pkg::vid_limits_t limits,
	input  logic                 cfg_ok,
	output vid_pkg::vid_sync_t   timing
);
	import vid_pkg::*;

	// pixel position within the line, 1 to h_total
	logic [vid_cnt_w-1:0] h_pos;
	// line position within the frame, 1 to v_total
	logic [vid_cnt_w-1:0] v_pos;
	// last pixel of the line
	logic                 line_end;
	// inside the active window
	logic                 h_active;
	logic                 v_active;
	// sync generation and two delay stages
	vid_sync_t            sync_gen;
	vid_sync_t            sync_dly1;
	vid_sync_t            sync_dly2;

	assign line_end = (h_pos >= limits.h_total);
	assign h_active = (h_pos >= limits.h_de_first) && (h_pos <= limits.h_de_last);
	assign v_active = (v_pos >= limits.v_de_first) && (v_pos <= limits.v_de_last);

	// ----------------------------------------------------------------------
	// pixel counter
	// ----------------------------------------------------------------------

	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
			h_pos <= vid_cnt_w'(1);
		else if (!cfg_ok)
			h_pos <= vid_cnt_w'(1);
		else if (line_end)
			h_pos <= vid_cnt_w'(1);
		else
			h_pos <= h_pos + vid_cnt_w'(1);
	end

	// ----------------------------------------------------------------------
	// line counter
	// ----------------------------------------------------------------------

	// new line number shows up together with pixel 1
	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
			v_pos <= vid_cnt_w'(1);
		else if (!cfg_ok)
			v_pos <= vid_cnt_w'(1);
		else if (line_end)
		begin
			if (v_pos >= limits.v_total)
				v_pos <= vid_cnt_w'(1);
			else
				v_pos <= v_pos + vid_cnt_w'(1);
		end
	end

	// ----------------------------------------------------------------------
	// sync, de and active counts
	// ----------------------------------------------------------------------

	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
			sync_gen <= '0;
		else if (!cfg_ok)
			sync_gen <= '0;
		else
		begin
			// hs from pixel 1 up to the sync width
			sync_gen.hs <= (h_pos <= limits.h_sync_end);
			// vs covers whole lines from line 1
			sync_gen.vs <= (v_pos <= limits.v_sync_end);
			sync_gen.de <= h_active && v_active;
			if (h_active && v_active)
			begin
				// renumber from 1 inside the window
				sync_gen.h_cnt <= h_pos - limits.h_de_first + vid_cnt_w'(1);
				sync_gen.v_cnt <= v_pos - limits.v_de_first + vid_cnt_w'(1);
			end
			else
			begin
				sync_gen.h_cnt <= '0;
				sync_gen.v_cnt <= '0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// output delay
	// ----------------------------------------------------------------------

	// two stages, whole bundle moves together
	always_ff @(posedge vid_clk_in or negedge reset_logic_n)
	begin
		if (!reset_logic_n)
		begin
			sync_dly1 <= '0;
			sync_dly2 <= '0;
		end
		else
		begin
			sync_dly1 <= sync_gen;
			sync_dly2 <= sync_dly1;
		end
	end

	assign timing = sync_dly2;

endmodule

// File: design/vid_tpg_top.sv
`timescale 1ns/1ps

module vid_tpg_top #(
	parameter int bar_shift   = 1,
	parameter int check_shift = 2
) (
	input  logic                  vid_clk_in,
	input  logic                  reset_logic_n,
	input  vid_pkg::vid_geom_t    geom,
	input  vid_pkg::vid_pattern_e pattern_sel,
	input  vid_pkg::vid_rgb_t     solid_rgb,
	output vid_pkg::vid_sync_t    sync_out,
	output vid_pkg::vid_rgb_t     pixel_out
);
	import vid_pkg::*;

	// ----------------------------------------------------------------------
	// stage links
	// ----------------------------------------------------------------------

	// compare values and geometry valid flag
	vid_limits_t limits;
	logic        cfg_ok;
	// raw timing ahead of the pattern stage
	vid_sync_t   timing;

	// porch sums and zero field check
	vid_timing_cfg u_timing_cfg (
		.vid_clk_in    (vid_clk_in),
		.reset_logic_n (reset_logic_n),
		.geom          (geom),
		.limits        (limits),
		.cfg_ok        (cfg_ok)
	);

	// counters and sync generation
	vid_timing_gen u_timing_gen (
		.vid_clk_in    (vid_clk_in),
		.reset_logic_n (reset_logic_n),
		.limits        (limits),
		.cfg_ok        (cfg_ok),
		.timing        (timing)
	);

	// rgb from active counts
	vid_pattern_gen #(
		.bar_shift   (bar_shift),
		.check_shift (check_shift)
	) u_pattern_gen (
		.vid_clk_in    (vid_clk_in),
		.reset_logic_n (reset_logic_n),
		.timing_in     (timing),
		.pattern_sel   (pattern_sel),
		.solid_rgb     (solid_rgb),
		.timing_out    (sync_out),
		.pixel         (pixel_out)
	);

endmodule

// File: run_sim.sh
#!/bin/bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_vid_tpg -o tb_vid_tpg_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_vid_tpg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// File: sources.f
design/vid_pkg.sv
design/vid_timing_cfg.sv
design/vid_timing_gen.sv
design/vid_pattern_gen.sv
design/vid_tpg_top.sv
tests/tb_vid_tpg.sv

// File: tests/tb_vid_tpg.sv
`timescale 1ns/1ps

module tb_vid_tpg;
	import vid_pkg::*;

	localparam int bar_shift   = 1;
	localparam int check_shift = 2;
	localparam int hpix = 16, hfp = 3, hbp = 4, hpw = 2;
	localparam int vpix = 6, vfp = 2, vbp = 2, vpw = 2;
	localparam int h_total = hpix + hfp + hbp + hpw;
	localparam int v_total = vpix + vfp + vbp + vpw;
	localparam int wait_limit = 2000;

	logic         vid_clk_in;
	logic         reset_logic_n;
	vid_geom_t    geom;
	vid_pattern_e pattern_sel;
	vid_rgb_t     solid_rgb;
	vid_sync_t    sync_out;
	vid_rgb_t     pixel_out;

	// monitor state
	int           seed = 26;
	int           errors, checks, passed, tests_run;
	bit           check_en, idle_chk, locked, hs_prev, de_prev;
	// a frame wait ran out
	bit           timed_out;
	int           hp, ln, de_pulses, frames_seen;
	vid_pattern_e exp_pat;
	vid_sync_t    exp_sync;
	vid_rgb_t     exp_pix;

	vid_tpg_top #(
		.bar_shift   (bar_shift),
		.check_shift (check_shift)
	) uut (
		.vid_clk_in    (vid_clk_in),
		.reset_logic_n (reset_logic_n),
		.geom          (geom),
		.pattern_sel   (pattern_sel),
		.solid_rgb     (solid_rgb),
		.sync_out      (sync_out),
		.pixel_out     (pixel_out)
	);

	always #20 vid_clk_in = ~vid_clk_in;

	// expected rgb for zero-based active position
	function automatic vid_rgb_t pattern_pixel(vid_pattern_e p, int h, int v);
		vid_rgb_t c;
		int       idx;
		idx = (h >> bar_shift) % 8;
		case (p)
			pat_bars:  c = {{8{idx[2]}}, {8{idx[1]}}, {8{idx[0]}}};
			pat_ramp:  c = {3{h[7:0]}};
			pat_check: c = (h[check_shift] != v[check_shift]) ? 24'hffffff : 24'h0;
			default:   c = solid_rgb;
		endcase
		return c;
	endfunction

	// ------------------------------------------------------------------
	// reference position model and checks
	// ------------------------------------------------------------------

	always @(posedge vid_clk_in)
	begin
		if (!check_en)
			locked = 0;
		else if (!locked)
		begin
			// sync to first line of a frame
			if (sync_out.hs && !hs_prev && sync_out.vs)
			begin
				locked      = 1;
				hp          = 0;
				ln          = 0;
				frames_seen = 0;
			end
		end
		else
		begin
			hp++;
			if (hp == h_total)
			begin
				hp = 0;
				ln = (ln + 1 == v_total) ? 0 : ln + 1;
			end
		end
		if (locked)
		begin
			if (hp == 0 && ln == 0)
			begin
				// one de pulse per active line
				if (frames_seen > 0)
				begin
					checks++;
					assert (de_pulses == vpix) passed++;
					else
					begin
						errors++;
						$display("Fail at %0t: %0d de pulses in frame", $time, de_pulses);
					end
				end
				de_pulses = 0;
				frames_seen++;
				exp_pat = pattern_sel;
			end
			exp_sync.hs = (hp < hpw);
			exp_sync.vs = (ln < vpw);
			exp_sync.de = (hp >= hpw + hbp) && (hp < hpw + hbp + hpix) &&
				(ln >= vpw + vbp) && (ln < vpw + vbp + vpix);
			exp_sync.h_cnt = exp_sync.de ? 16'(hp - hpw - hbp + 1) : 16'd0;
			exp_sync.v_cnt = exp_sync.de ? 16'(ln - vpw - vbp + 1) : 16'd0;
			exp_pix = exp_sync.de ?
				pattern_pixel(exp_pat, exp_sync.h_cnt - 1, exp_sync.v_cnt - 1) : 24'h0;
			checks++;
			assert (sync_out == exp_sync) passed++;
			else
			begin
				errors++;
				$display("Fail at %0t: sync %h expected %h", $time, sync_out, exp_sync);
			end
			checks++;
			assert (pixel_out == exp_pix) passed++;
			else
			begin
				errors++;
				$display("Fail at %0t: pixel %h expected %h", $time, pixel_out, exp_pix);
			end
			if (sync_out.de && !de_prev)
				de_pulses++;
		end
		if (idle_chk)
		begin
			checks++;
			assert (!sync_out.hs && !sync_out.vs && !sync_out.de && pixel_out == '0) passed++;
			else
			begin
				errors++;
				$display("Fail at %0t: output active while idle", $time);
			end
		end
		hs_prev = sync_out.hs;
		de_prev = sync_out.de;
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------

	task automatic wait_frame_start();
		int  n;
		bit  vs_old;
		n      = 0;
		vs_old = sync_out.vs;
		@(negedge vid_clk_in);
		while (!timed_out && !(sync_out.vs && !vs_old))
		begin
			vs_old = sync_out.vs;
			n++;
			if (n > wait_limit)
			begin
				timed_out = 1;
				$display("timeout: no vertical sync from the DUT");
			end
			else
				@(negedge vid_clk_in);
		end
	endtask

	task automatic report_test(string name, int err_before);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
	endtask

	initial
	begin
		int e;
		vid_clk_in    = 0;
		reset_logic_n = 0;
		geom          = '{16'(hpix), 16'(hfp), 16'(hbp), 16'(hpw),
			16'(vpix), 16'(vfp), 16'(vbp), 16'(vpw)};
		pattern_sel   = pat_bars;
		solid_rgb     = 24'($random(seed));
		errors = 0;
		checks = 0;
		passed = 0;
		tests_run = 0;
		check_en = 0;
		locked = 0;
		hs_prev = 0;
		de_prev = 0;
		timed_out = 0;
		idle_chk = 1;
		repeat (5) @(negedge vid_clk_in);
		reset_logic_n = 1;
		idle_chk      = 0;
		check_en      = 1;

		// syncs, de, counts over whole frames
		e = errors;
		wait_frame_start();
		wait_frame_start();
		wait_frame_start();
		report_test("horizontal timing", e);
		e = errors;
		wait_frame_start();
		report_test("vertical timing", e);
		e = errors;
		wait_frame_start();
		report_test("active counts", e);

		// each mode selected mid-frame, checked the frame after
		e = errors;
		for (int p = 1; p < 5; p++)
		begin
			repeat (h_total * 5) @(negedge vid_clk_in);
			pattern_sel = vid_pattern_e'(p % 4);
			wait_frame_start();
			wait_frame_start();
		end
		report_test("patterns", e);

		// old rule holds until the frame boundary
		e = errors;
		repeat (h_total * 6) @(negedge vid_clk_in);
		pattern_sel = pat_check;
		wait_frame_start();
		repeat (h_total * 6) @(negedge vid_clk_in);
		pattern_sel = pat_ramp;
		wait_frame_start();
		wait_frame_start();
		report_test("frame aligned select", e);

		// zero sync width stops the stream
		e = errors;
		check_en     = 0;
		geom.hpwidth = '0;
		repeat (8) @(negedge vid_clk_in);
		idle_chk = 1;
		repeat (h_total * v_total) @(negedge vid_clk_in);
		idle_chk     = 0;
		geom.hpwidth = 16'(hpw);
		repeat (2) @(negedge vid_clk_in);
		check_en = 1;
		wait_frame_start();
		wait_frame_start();
		wait_frame_start();
		report_test("reset and invalid geometry", e);

		$display("tests %0d, checks %0d, passed %0d, errors %0d",
			tests_run, checks, passed, errors);
		if (errors == 0 && checks > 0 && passed == checks && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
